// File: fdc.f
hw/fdc_pkg.sv
hw/fdc_host_port.sv
hw/fdc_command_fsm.sv
hw/fdc_drive_state.sv
hw/fdc_top.sv
testbench/fdc_properties.sv
testbench/fdc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fdc testbench with Verilator

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing -f fdc.f --top-module fdc_tb -o fdc_sim \
	&& ./obj_dir/fdc_sim > "$LOG" 2>&1 \
	|| echo "build or simulation did not complete"

[ -f "$LOG" ] && cat "$LOG"

grep -q "Finished with errors" "$LOG" 2>/dev/null && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" "$LOG" 2>/dev/null && { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

// File: testbench/fdc_tb.sv
// fdc core testbench

`timescale 1ns/1ps

module fdc_tb import fdc_pkg::*; ();

	logic  clk_sys = 1'b0;
	logic  rst;
	logic  ready;
	logic  disk_present;
	logic  a0;
	logic  nRD;
	logic  nWR;
	byte_t disk_tracks;
	byte_t din;
	byte_t dout;

	integer seed = 32'h7273;
	integer errors = 0;
	integer checks = 0;
	integer tests = 0;
	integer failed_tests = 0;
	integer test_start = 0;  // error count when the current test began
	byte_t  model_pcn;

	always #10 clk_sys = ~clk_sys;  // 20 ns period

	fdc_top UUT (
		.clk_sys(clk_sys), .rst(rst), .ready(ready), .disk_present(disk_present),
		.disk_tracks(disk_tracks), .a0(a0), .nRD(nRD), .nWR(nWR), .din(din), .dout(dout)
	);

	// ==============================
	// reference model
	// ==============================

	// {st0, pcn} after a seek from cur_pcn
	function automatic logic [15:0] expected_seek(input byte_t cur_pcn, input byte_t target,
			input logic rdy, input logic present, input byte_t tracks);
		if ((target == 8'd0) || (rdy && present && (target < tracks)))
			return {8'h20, target};
		else
			return {8'hE8, cur_pcn};  // head stays where it was
	endfunction

	// ==============================
	// host bus tasks
	// ==============================

	task automatic step(input integer n);
		repeat (n) @(posedge clk_sys);
		#1;  // inputs move just after the edge
	endtask

	task automatic write_byte(input logic addr, input byte_t data);
		a0 = addr;
		din = data;
		nWR = 1'b0;
		step(3);
		nWR = 1'b1;
		step(2);
	endtask

	task automatic read_byte(input logic addr, output byte_t data);
		a0 = addr;
		nRD = 1'b0;
		step(3);
		data = dout;  // just before release
		nRD = 1'b1;
		step(2);
	endtask

	task automatic check_value(input string name, input byte_t got, input byte_t exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("[ERROR] %0t ns %s got %02h expected %02h", $time, name, got, exp);
		end
	endtask

	// polls the status register, bounded
	task automatic wait_status(input byte_t mask, input byte_t value, input string what);
		byte_t  msr;
		integer tries;
		logic   seen;
		seen = 1'b0;
		tries = 0;
		while (!seen && (tries < 16)) begin
			read_byte(1'b0, msr);
			seen = ((msr & mask) == value);
			tries = tries + 1;
		end
		if (!seen) begin
			errors = errors + 1;
			$display("timeout: the status register never showed %s", what);
		end
	endtask

	// ==============================
	// command sequences
	// ==============================

	task automatic sense_interrupt(input byte_t exp_st0, input byte_t exp_pcn);
		byte_t val;
		write_byte(1'b1, 8'h08);
		wait_status(8'hC0, 8'hC0, "a result byte");
		read_byte(1'b1, val);
		check_value("st0", val, exp_st0);
		read_byte(1'b1, val);
		check_value("pcn", val, exp_pcn);
	endtask

	// single 0x80 result, then back to idle
	task automatic expect_invalid(input byte_t opcode);
		byte_t val;
		write_byte(1'b1, opcode);
		wait_status(8'hC0, 8'hC0, "a result byte");
		read_byte(1'b1, val);
		check_value("result", val, 8'h80);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h80);
	endtask

	task automatic recalibrate();
		write_byte(1'b1, 8'h07);
		write_byte(1'b1, 8'h00);
		wait_status(8'h10, 8'h00, "the command finished");
		model_pcn = 8'd0;
	endtask

	task automatic seek_to(input byte_t target);
		logic [15:0] exp;
		write_byte(1'b1, 8'h0F);
		write_byte(1'b1, 8'h00);
		write_byte(1'b1, target);
		wait_status(8'h10, 8'h00, "the command finished");
		exp = expected_seek(model_pcn, target, ready, disk_present, disk_tracks);
		sense_interrupt(exp[15:8], exp[7:0]);
		model_pcn = exp[7:0];
	endtask

	task automatic sense_drive(input logic us0, input byte_t exp);
		byte_t val;
		write_byte(1'b1, 8'h04);
		write_byte(1'b1, {7'd0, us0});
		wait_status(8'hC0, 8'hC0, "a result byte");
		read_byte(1'b1, val);
		check_value("st3", val, exp);
	endtask

	task automatic end_test(input string name);
		tests = tests + 1;
		if (errors != test_start) begin
			failed_tests = failed_tests + 1;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: passed", name);
		end
		test_start = errors;
	endtask

	// ==============================
	// test sequence
	// ==============================

	initial begin
		byte_t  val;
		integer i;
		rst = 1'b1;
		ready = 1'b1;
		disk_present = 1'b1;
		disk_tracks = 8'd40;
		a0 = 1'b0;
		nRD = 1'b1;
		nWR = 1'b1;
		din = 8'h00;
		model_pcn = 8'd0;
		step(5);
		rst = 1'b0;
		step(2);

		check_value("dout", dout, 8'h00);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h80);
		expect_invalid(8'h08);  // nothing pending yet
		end_test("reset");

		recalibrate();
		sense_interrupt(8'h20, 8'h00);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h80);
		expect_invalid(8'h08);
		end_test("recalibrate");

		for (i = 0; i < 12; i = i + 1) begin
			val = 8'($random(seed) & 32'h3F);  // 0..63, some past track 39
			seek_to(val);
		end
		seek_to(8'd50);
		seek_to(8'd0);
		end_test("seek");

		recalibrate();
		sense_interrupt(8'h20, 8'h00);
		sense_drive(1'b0, 8'h30);
		seek_to(8'd5);
		sense_drive(1'b0, 8'h20);
		recalibrate();
		sense_interrupt(8'h20, 8'h00);
		disk_present = 1'b0;
		step(2);
		sense_drive(1'b0, 8'h50);
		sense_drive(1'b1, 8'h01);
		disk_present = 1'b1;
		end_test("drive_status");

		write_byte(1'b1, 8'h03);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h90);
		write_byte(1'b1, 8'hAF);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h90);
		write_byte(1'b1, 8'h02);
		read_byte(1'b0, val);
		check_value("msr", val, 8'h80);
		expect_invalid(8'h06);  // read data is not supported here
		end_test("status_register");

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: testbench/fdc_properties.sv
// fdc command fsm assertions

`timescale 1ns/1ps

module fdc_properties import fdc_pkg::*; (
	input logic       clk_sys,
	input logic       rst,
	input logic       data_wr,
	input logic       data_rd,
	input logic       int_ack,
	input logic       dio,
	input fdc_phase_t phase
);

	// host port never reports both strobes at once
	a_wr_rd_exclusive: assert property (@(posedge clk_sys) disable iff (rst)
		!(data_wr && data_rd))
		else $error("data_wr and data_rd high in the same cycle");

	a_ack_single: assert property (@(posedge clk_sys) disable iff (rst)
		int_ack |=> !int_ack)
		else $error("int_ack held for two cycles");

	// ==============================
	a_dio_idle: assert property (@(posedge clk_sys) disable iff (rst)
		(phase == phase_idle) |-> !dio)
		else $error("dio high while the fsm is idle");

endmodule

bind fdc_command_fsm fdc_properties u_properties (
	.clk_sys(clk_sys), .rst(rst), .data_wr(data_wr), .data_rd(data_rd),
	.int_ack(int_ack), .dio(dio), .phase(phase)
);

// File: hw/fdc_top.sv
// fdc core top level

`timescale 1ns/1ps

module fdc_top import fdc_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  ready,
	input  logic  disk_present,
	input  byte_t disk_tracks,
	input  logic  a0,
	input  logic  nRD,
	input  logic  nWR,
	input  byte_t din,
	output byte_t dout
);

	// host port <-> fsm
	logic  data_wr;
	logic  data_rd;
	byte_t wr_byte;
	byte_t result_byte;
	logic  dio;
	logic  cb;

	// fsm <-> drive state
	logic  seek_req;
	logic  recal_req;
	logic  int_ack;
	logic  int_pending;
	byte_t ncn;
	byte_t pcn;
	byte_t st0;
	byte_t st3;

	fdc_host_port u_host_port (
		.clk_sys, .rst, .nRD, .nWR, .a0, .din, .result_byte, .dio, .cb,
		.data_wr, .data_rd, .wr_byte, .dout
	);

	fdc_command_fsm u_command_fsm (
		.clk_sys, .rst, .data_wr, .data_rd, .wr_byte, .pcn, .st0, .st3, .int_pending,
		.result_byte, .dio, .cb, .seek_req, .recal_req, .ncn, .int_ack
	);

	fdc_drive_state u_drive_state (
		.clk_sys, .rst, .ready, .disk_present, .disk_tracks, .seek_req, .recal_req,
		.ncn, .int_ack, .pcn, .st0, .st3, .int_pending
	);

endmodule

// File: hw/fdc_drive_state.sv
// fdc drive state

`timescale 1ns/1ps

module fdc_drive_state import fdc_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  ready,
	input  logic  disk_present,
	input  byte_t disk_tracks,
	input  logic  seek_req,
	input  logic  recal_req,
	input  byte_t ncn,
	input  logic  int_ack,
	output byte_t pcn,
	output byte_t st0,
	output byte_t st3,
	output logic  int_pending
);

	logic seek_ok;
	logic t0;  // head on track 0

	// track 0 is always reachable, others need a ready disk
	assign seek_ok = (ncn == '0) || (ready && disk_present && (ncn < disk_tracks));

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pcn         <= '0;
			st0         <= '0;
			t0          <= 1'b1;
			int_pending <= 1'b0;
		end else begin
			if (recal_req) begin
				pcn <= '0;
				st0 <= st0_seek_ok;
				t0  <= 1'b1;
			end else if (seek_req) begin
				if (seek_ok) begin
					pcn <= ncn;
					st0 <= st0_seek_ok;
					t0  <= (ncn == '0);
				end else begin
					st0 <= st0_seek_err;  // head stays put
				end
			end

			// a new request wins over the ack
			if (seek_req || recal_req)
				int_pending <= 1'b1;
			else if (int_ack)
				int_pending <= 1'b0;
		end
	end

	// st3, write protected without a disk
	always_comb begin
		st3 = '0;
		st3[st3_wp]  = ~disk_present;
		st3[st3_rdy] = disk_present;
		st3[st3_t0]  = t0;
	end

endmodule

// File: hw/fdc_command_fsm.sv
// fdc command sequencer

`timescale 1ns/1ps

module fdc_command_fsm import fdc_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  data_wr,
	input  logic  data_rd,
	input  byte_t wr_byte,
	input  byte_t pcn,
	input  byte_t st0,
	input  byte_t st3,
	input  logic  int_pending,
	output byte_t result_byte,
	output logic  dio,
	output logic  cb,
	output logic  seek_req,
	output logic  recal_req,
	output byte_t ncn,
	output logic  int_ack
);

	fdc_phase_t phase;
	byte_t      cmd;          // accepted opcode
	logic       param_cnt;    // set after the first parameter byte
	logic       res_idx;      // result byte index
	logic       drive_sel;    // us0 of sense drive status
	logic       last_param;
	logic       last_result;
	byte_t      result_next;

	// specify and seek take two bytes, the rest one
	assign last_param  = ((cmd == op_specify) || (cmd == op_seek)) ? param_cnt : 1'b1;
	assign last_result = (cmd == op_sense_int) ? res_idx : 1'b1;

	// ==============================
	// drive requests
	// ==============================

	assign int_ack   = data_wr && (phase == phase_idle);
	assign recal_req = data_wr && (phase == phase_params) && (cmd == op_recalibrate);
	assign seek_req  = data_wr && (phase == phase_params) && (cmd == op_seek) && last_param;
	assign ncn       = wr_byte;  // the host port holds the last byte written

	// status register levels
	assign dio = (phase == phase_result) || (phase == phase_invalid);
	assign cb  = (phase == phase_params) || (phase == phase_result);

	// ==============================
	// phase sequencing
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			phase     <= phase_idle;
			cmd       <= '0;
			param_cnt <= 1'b0;
			res_idx   <= 1'b0;
		end else begin
			case (phase)
				phase_idle: begin
					if (data_wr) begin
						cmd       <= wr_byte;
						param_cnt <= 1'b0;
						res_idx   <= 1'b0;
						case (wr_byte)
							op_specify, op_sense_drive, op_recalibrate, op_seek:
								phase <= phase_params;
							// pending flag sampled before int_ack clears it
							op_sense_int:
								phase <= int_pending ? phase_result : phase_invalid;
							default:
								phase <= phase_invalid;
						endcase
					end
				end
				phase_params: begin
					if (data_wr) begin
						param_cnt <= 1'b1;
						if (last_param)
							phase <= (cmd == op_sense_drive) ? phase_result : phase_idle;
					end
				end
				phase_result: begin
					if (data_rd) begin
						res_idx <= 1'b1;
						if (last_result)
							phase <= phase_idle;
					end
				end
				phase_invalid: begin
					if (data_rd)
						phase <= phase_idle;
				end
				default: phase <= phase_idle;
			endcase
		end
	end

	// drive select bit of the sense drive status byte
	always_ff @(posedge clk_sys) begin
		if (data_wr && (phase == phase_params) && (cmd == op_sense_drive))
			drive_sel <= wr_byte[0];
	end

	// ==============================
	// result byte
	// ==============================

	always_comb begin
		result_next = idle_data_byte;
		case (phase)
			phase_result: begin
				if (cmd == op_sense_int)
					result_next = res_idx ? pcn : st0;
				else
					result_next = drive_sel ? 8'h01 : st3;  // only drive 0 exists
			end
			phase_invalid: result_next = st0_invalid;
			default:       result_next = idle_data_byte;
		endcase
	end

	// one cycle behind the phase, settled long before the next read
	always_ff @(posedge clk_sys) begin
		if (rst)
			result_byte <= idle_data_byte;
		else
			result_byte <= result_next;
	end

endmodule

// File: hw/fdc_host_port.sv
// fdc host bus port

`timescale 1ns/1ps

module fdc_host_port import fdc_pkg::*; (
	input  logic  clk_sys,
	input  logic  rst,
	input  logic  nRD,
	input  logic  nWR,
	input  logic  a0,
	input  byte_t din,
	input  byte_t result_byte,
	input  logic  dio,
	input  logic  cb,
	output logic  data_wr,
	output logic  data_rd,
	output byte_t wr_byte,
	output byte_t dout
);

	logic  wr_lvl;   // write strobe active, read idle
	logic  rd_lvl;
	logic  wr_prev;
	logic  rd_prev;
	logic  wr_evt;
	logic  rd_evt;
	logic  stat_rd;  // status register read pulse
	byte_t msr;

	assign wr_lvl = ~nWR & nRD;
	assign rd_lvl = ~nRD & nWR;
	assign wr_evt = wr_lvl & ~wr_prev;
	assign rd_evt = rd_lvl & ~rd_prev;

	// rqm stays set, no execution phase here
	always_comb begin
		msr = '0;
		msr[msr_rqm] = 1'b1;
		msr[msr_dio] = dio;
		msr[msr_cb]  = cb;
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			wr_prev <= 1'b0;
			rd_prev <= 1'b0;
			data_wr <= 1'b0;
			data_rd <= 1'b0;
			stat_rd <= 1'b0;
			dout    <= '0;
		end else begin
			wr_prev <= wr_lvl;
			rd_prev <= rd_lvl;
			data_wr <= wr_evt & a0;  // a0 low writes go nowhere
			data_rd <= rd_evt & a0;
			stat_rd <= rd_evt & ~a0;
			if (stat_rd)
				dout <= msr;
			else if (data_rd)
				dout <= result_byte;  // fsm steps on the same edge
		end
	end

	// data byte latch, held until the next write
	always_ff @(posedge clk_sys) begin
		if (wr_evt & a0)
			wr_byte <= din;
	end

endmodule

// File: hw/fdc_pkg.sv
// fdc shared definitions

package fdc_pkg;

	// ==============================
	// data types
	// ==============================

	typedef logic [7:0] byte_t;  // one host data byte

	// command phases, 2 bits
	typedef enum logic [1:0] {
		phase_idle,     // waiting for an opcode
		phase_params,   // collecting parameter bytes
		phase_result,   // host reads result bytes
		phase_invalid   // single 0x80 result
	} fdc_phase_t;

	// ==============================
	// opcodes, full first byte
	// ==============================

	localparam byte_t op_specify     = 8'h03;
	localparam byte_t op_sense_drive = 8'h04;
	localparam byte_t op_recalibrate = 8'h07;
	localparam byte_t op_sense_int   = 8'h08;
	localparam byte_t op_seek        = 8'h0F;

	// main status register bits
	localparam logic [2:0] msr_rqm = 3'd7;
	localparam logic [2:0] msr_dio = 3'd6;
	localparam logic [2:0] msr_cb  = 3'd4;

	// st3 bits
	localparam logic [2:0] st3_t0  = 3'd4;
	localparam logic [2:0] st3_rdy = 3'd5;
	localparam logic [2:0] st3_wp  = 3'd6;

	// st0 values after seek / recal / bad command
	localparam byte_t st0_seek_ok  = 8'h20;  // seek end
	localparam byte_t st0_seek_err = 8'hE8;  // abnormal, seek end, not ready
	localparam byte_t st0_invalid  = 8'h80;

	localparam byte_t idle_data_byte = 8'hFF;  // data read with nothing to return

endpackage
